// ==== rtl/seg7_pkg.sv ====
`default_nettype none

package seg7_pkg;

    // one hex digit
    typedef logic [3:0] nibble_t;

    // scan position, digit 0 is the rightmost
    typedef logic [1:0] digit_idx_t;

    // active low digit enables, bit n drives digit n
    typedef logic [3:0] anode_t;

    // active low segments a..g in bits 0..6, point in bit 7
    typedef logic [7:0] seg_pattern_t;

    typedef struct packed {
        nibble_t [3:0] digits;
        logic [3:0]    dot_mask;
        logic [3:0]    blank_mask;
    } display_frame_t;

    // one digit picked out of the frame
    typedef struct packed {
        digit_idx_t idx;
        nibble_t    value;
        logic       dot;
        logic       blank;
    } digit_sel_t;

    // everything dark
    localparam anode_t       ANODE_OFF = '1;
    localparam seg_pattern_t SEG_OFF   = '1;

endpackage

`default_nettype wire

// ==== rtl/reset_sync.sv ====
`timescale 1ns/1ps
`default_nettype none

module reset_sync (
    input  wire logic clk_sys,
    input  wire logic rst_n,
    output logic      rst_sync_n
);

    logic rst_meta_n;

    // assert at once, release after two edges
    always_ff @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n) begin
            rst_meta_n <= 1'b0;
            rst_sync_n <= 1'b0;
        end else begin
            rst_meta_n <= 1'b1;
            rst_sync_n <= rst_meta_n;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/scan_tick_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module scan_tick_gen #(
    parameter int TICK_DIV = 100000
) (
    input  wire logic clk_sys,
    input  wire logic rst_n,
    output logic      scan_tick
);

    localparam int CNT_W = (TICK_DIV > 1) ? $clog2(TICK_DIV) : 1;
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(TICK_DIV - 1);

    logic [CNT_W-1:0] tick_cnt;
    logic             cnt_wrap;

    assign cnt_wrap = (tick_cnt == CNT_LAST);

    always_ff @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n) begin
            tick_cnt <= '0;
        end else if (cnt_wrap) begin
            tick_cnt <= '0;
        end else begin
            tick_cnt <= tick_cnt + 1'b1;
        end
    end

    // pulse lands the cycle after the wrap
    always_ff @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n) begin
            scan_tick <= 1'b0;
        end else begin
            scan_tick <= cnt_wrap;
        end
    end

    assert property (
        @(posedge clk_sys) disable iff (!rst_n) scan_tick |=> !scan_tick
    ) else $error("scan_tick_gen: tick wider than one cycle");

endmodule

`default_nettype wire

// ==== rtl/digit_scanner.sv ====
`timescale 1ns/1ps
`default_nettype none

module digit_scanner
    import seg7_pkg::*;
(
    input  wire logic           clk_sys,
    input  wire logic           rst_n,
    input  wire logic           scan_tick,
    input  wire display_frame_t frame,
    output digit_sel_t          sel,
    output logic                sel_valid
);

    digit_idx_t idx_q;
    digit_idx_t idx_next;
    nibble_t    value_q;
    logic       dot_q;
    logic       blank_q;

    // wraps 3 -> 0 by width
    assign idx_next = idx_q + 1'b1;

    // starts at 3 so the first tick lands on digit 0
    always_ff @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n) begin
            idx_q <= 2'd3;
        end else if (scan_tick) begin
            idx_q <= idx_next;
        end
    end

    // frame fields for the new digit, sampled on the tick only
    always_ff @(posedge clk_sys) begin
        if (scan_tick) begin
            value_q <= frame.digits[idx_next];
            dot_q   <= frame.dot_mask[idx_next];
            blank_q <= frame.blank_mask[idx_next];
        end
    end

    // sticky once the first digit is loaded
    always_ff @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n) begin
            sel_valid <= 1'b0;
        end else if (scan_tick) begin
            sel_valid <= 1'b1;
        end
    end

    assign sel.idx   = idx_q;
    assign sel.value = value_q;
    assign sel.dot   = dot_q;
    assign sel.blank = blank_q;

    assert property (
        @(posedge clk_sys) disable iff (!rst_n)
        !$stable(idx_q) |-> $past(scan_tick)
    ) else $error("digit_scanner: index moved without a tick");

endmodule

`default_nettype wire

// ==== rtl/seg7_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module seg7_decoder
    import seg7_pkg::*;
(
    input  wire logic       clk_sys,
    input  wire logic       rst_n,
    input  wire digit_sel_t sel,
    input  wire logic       sel_valid,
    output anode_t          seg_select,
    output seg_pattern_t    hex_out
);

    // active low a..g for one hex value
    function automatic logic [6:0] glyph(input nibble_t value);
        logic [6:0] lit;
        case (value)
            4'h0: lit = 7'h3F;
            4'h1: lit = 7'h06;
            4'h2: lit = 7'h5B;
            4'h3: lit = 7'h4F;
            4'h4: lit = 7'h66;
            4'h5: lit = 7'h6D;
            4'h6: lit = 7'h7D;
            4'h7: lit = 7'h07;
            4'h8: lit = 7'h7F;
            4'h9: lit = 7'h6F;
            4'hA: lit = 7'h77;
            4'hB: lit = 7'h7C;
            4'hC: lit = 7'h39;
            4'hD: lit = 7'h5E;
            4'hE: lit = 7'h79;
            default: lit = 7'h71;
        endcase
        return ~lit;
    endfunction

    always_ff @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n) begin
            seg_select <= ANODE_OFF;
            hex_out    <= SEG_OFF;
        end else if (!sel_valid) begin
            seg_select <= ANODE_OFF;
            hex_out    <= SEG_OFF;
        end else begin
            // one cold anode for the scanned digit
            seg_select <= anode_t'(~(4'b0001 << sel.idx));
            if (sel.blank) begin
                hex_out <= SEG_OFF;
            end else begin
                hex_out <= {~sel.dot, glyph(sel.value)};
            end
        end
    end

    assert property (
        @(posedge clk_sys) disable iff (!rst_n) $onehot0(~seg_select)
    ) else $error("seg7_decoder: more than one digit enabled");

endmodule

`default_nettype wire

// ==== rtl/seg7_display_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module seg7_display_top
    import seg7_pkg::*;
#(
    parameter int TICK_DIV = 100000
) (
    input  wire logic           clk_sys,
    input  wire logic           rst_n,
    input  wire display_frame_t frame,
    output anode_t              seg_select,
    output seg_pattern_t        hex_out
);

    logic       rst_sync_n;
    logic       scan_tick;
    digit_sel_t sel;
    logic       sel_valid;

    reset_sync u_reset_sync (
        .clk_sys    (clk_sys),
        .rst_n      (rst_n),
        .rst_sync_n (rst_sync_n)
    );

    // sets the per digit dwell time
    scan_tick_gen #(
        .TICK_DIV (TICK_DIV)
    ) u_scan_tick_gen (
        .clk_sys   (clk_sys),
        .rst_n     (rst_sync_n),
        .scan_tick (scan_tick)
    );

    digit_scanner u_digit_scanner (
        .clk_sys   (clk_sys),
        .rst_n     (rst_sync_n),
        .scan_tick (scan_tick),
        .frame     (frame),
        .sel       (sel),
        .sel_valid (sel_valid)
    );

    seg7_decoder u_seg7_decoder (
        .clk_sys    (clk_sys),
        .rst_n      (rst_sync_n),
        .sel        (sel),
        .sel_valid  (sel_valid),
        .seg_select (seg_select),
        .hex_out    (hex_out)
    );

endmodule

`default_nettype wire

// ==== sim/tb_seg7_display.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_seg7_display
    import seg7_pkg::*;
();

    localparam int TICK_DIV   = 8;
    localparam int NUM_SCANS  = 240;
    localparam int WAIT_LIMIT = 40;

    logic           clk_sys;
    logic           rst_n;
    display_frame_t frame;
    anode_t         seg_select;
    seg_pattern_t   hex_out;

    int        seed;
    bit        timed_out;
    anode_t    last_sel;
    int        exp_idx;
    int        fail_count[string];
    int        tests_passed;
    int        tests_failed;
    bit [15:0] seen_value;
    int        blank_seen;
    int        dot_seen;
    int        cycles;

    seg7_display_top #(
        .TICK_DIV (TICK_DIV)
    ) uut (
        .clk_sys    (clk_sys),
        .rst_n      (rst_n),
        .frame      (frame),
        .seg_select (seg_select),
        .hex_out    (hex_out)
    );

    initial begin
        clk_sys = 1'b0;
        forever #4 clk_sys = ~clk_sys;
    end

    // lit segments, g down to a
    function automatic logic [6:0] ref_glyph(input nibble_t value);
        case (value)
            4'h0: return 7'b0111111;
            4'h1: return 7'b0000110;
            4'h2: return 7'b1011011;
            4'h3: return 7'b1001111;
            4'h4: return 7'b1100110;
            4'h5: return 7'b1101101;
            4'h6: return 7'b1111101;
            4'h7: return 7'b0000111;
            4'h8: return 7'b1111111;
            4'h9: return 7'b1101111;
            4'hA: return 7'b1110111;
            4'hB: return 7'b1111100;
            4'hC: return 7'b0111001;
            4'hD: return 7'b1011110;
            4'hE: return 7'b1111001;
            default: return 7'b1110001;
        endcase
    endfunction

    function automatic seg_pattern_t expected_segments(input display_frame_t f,
                                                       input int idx);
        logic [6:0] lit;
        lit = ref_glyph(f.digits[idx]);
        if (f.blank_mask[idx]) begin
            return 8'hFF;
        end
        return {~f.dot_mask[idx], ~lit};
    endfunction

    function automatic display_frame_t random_frame();
        display_frame_t f;
        int             r_val;
        int             r_mask;
        r_val  = $random(seed);
        r_mask = $random(seed);
        f.digits   = r_val[15:0];
        f.dot_mask = r_mask[3:0];
        // roughly one digit in four blanked
        f.blank_mask = r_mask[7:4] & r_mask[11:8];
        return f;
    endfunction

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (expected !== actual) begin
            $display("mismatch in %s: expected %0h, actual %0h", name, expected, actual);
            fail_count[name]++;
        end
    endtask

    task automatic note_failure(input string name, input string what);
        $display("%s: %s", name, what);
        fail_count[name]++;
    endtask

    task automatic report_test(input string name);
        if (fail_count[name] == 0) begin
            $display("test %s passed", name);
            tests_passed++;
        end else begin
            $display("test %s failed with %0d errors", name, fail_count[name]);
            tests_failed++;
        end
    endtask

    // samples on the falling edge, away from the DUT's updates
    task automatic wait_scan_change(input string name, input bit hold_reset,
                                    output int n);
        n = 0;
        timed_out = 1'b1;
        while (n < WAIT_LIMIT) begin
            @(negedge clk_sys);
            n++;
            if (seg_select !== last_sel) begin
                timed_out = 1'b0;
                break;
            end
            if (hold_reset) begin
                check("reset", 32'hFF, 32'(hex_out));
            end
        end
        if (timed_out) begin
            note_failure(name, $sformatf("no scan change within %0d cycles", WAIT_LIMIT));
        end
    endtask

    task automatic check_scan(input int n, input bit check_period);
        int           idx;
        int           low_count;
        seg_pattern_t exp_seg;
        logic         exp_dot;
        idx = -1;
        low_count = 0;
        for (int i = 0; i < 4; i++) begin
            if (seg_select[i] == 1'b0) begin
                idx = i;
                low_count++;
            end
        end
        check("scan_order", 32'(1), 32'(low_count));
        check("scan_order", 32'(exp_idx), 32'(idx));
        if (check_period) begin
            check("scan_period", 32'(TICK_DIV), 32'(n));
        end
        exp_idx = (exp_idx + 1) % 4;
        last_sel = seg_select;
        if (low_count != 1) begin
            return;
        end
        exp_seg = expected_segments(frame, idx);
        if (frame.blank_mask[idx]) begin
            blank_seen++;
            check("blanking", 32'hFF, 32'(hex_out));
        end else begin
            exp_dot = ~frame.dot_mask[idx];
            seen_value[frame.digits[idx]] = 1'b1;
            if (!exp_dot) begin
                dot_seen++;
            end
            check("hex_decode", 32'(exp_seg[6:0]), 32'(hex_out[6:0]));
            check("decimal_point", 32'(exp_dot), 32'(hex_out[7]));
        end
    endtask

    initial begin
        seed = 99611;
        timed_out = 1'b0;
        last_sel = 4'hF;
        exp_idx = 0;
        seen_value = '0;
        blank_seen = 0;
        dot_seen = 0;
        tests_passed = 0;
        tests_failed = 0;
        fail_count["reset"] = 0;
        fail_count["scan_order"] = 0;
        fail_count["hex_decode"] = 0;
        fail_count["decimal_point"] = 0;
        fail_count["blanking"] = 0;
        fail_count["scan_period"] = 0;
        rst_n = 1'b0;
        frame = random_frame();

        repeat (16) begin
            @(negedge clk_sys);
            check("reset", 32'hF, 32'(seg_select));
            check("reset", 32'hFF, 32'(hex_out));
        end
        @(posedge clk_sys);
        rst_n <= 1'b1;

        // first digit appears only after the synchronizer and one full divide
        wait_scan_change("reset", 1'b1, cycles);
        report_test("reset");
        if (!timed_out) begin
            check_scan(cycles, 1'b0);
            @(posedge clk_sys);
            frame <= random_frame();
            for (int s = 0; s < NUM_SCANS; s++) begin
                wait_scan_change("scan_order", 1'b0, cycles);
                if (timed_out) begin
                    break;
                end
                check_scan(cycles, 1'b1);
                // new frame well ahead of the next tick
                @(posedge clk_sys);
                frame <= random_frame();
            end
        end

        if (!timed_out) begin
            if (seen_value != 16'hFFFF) begin
                note_failure("hex_decode", "not every hex value was shown on a digit");
            end
            if (blank_seen == 0) begin
                note_failure("blanking", "no blanked digit was ever scanned");
            end
            if (dot_seen == 0) begin
                note_failure("decimal_point", "no lit decimal point was ever scanned");
            end
        end
        report_test("scan_order");
        report_test("hex_decode");
        report_test("decimal_point");
        report_test("blanking");
        report_test("scan_period");

        $display("tests passed %0d, failed %0d", tests_passed, tests_failed);
        if (timed_out || tests_failed != 0) begin
            $display("TESTBENCH FAILED");
        end else begin
            $display("TESTBENCH PASSED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== compile.f ====
rtl/seg7_pkg.sv
rtl/reset_sync.sv
rtl/scan_tick_gen.sv
rtl/digit_scanner.sv
rtl/seg7_decoder.sv
rtl/seg7_display_top.sv
sim/tb_seg7_display.sv

// ==== Makefile ====
TOOL     := verilator
FLAGS    := --binary --timing --assert -j 0
TOP      := tb_seg7_display
FILELIST := compile.f
PASS_MSG := TESTBENCH PASSED
SIM_BIN  := obj_dir/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: compile
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf obj_dir
